// ==== build.f ====
hdl/ig_pkg.sv
hdl/pixel_fetch.sv
hdl/line_window.sv
hdl/gradient_calc.sv
hdl/grad_writer.sv
hdl/ig_top.sv
verif/ig_tb.sv

// ==== hdl/grad_writer.sv ====
`timescale 1ns/1ps

module grad_writer
    import ig_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  grad_beat_t        grad,
    output logic              grad_wr,
    output logic [addr_w-1:0] grad_addr,
    output logic [grad_w-1:0] grad_do,
    output logic              done
);

    logic last_write;

    assign last_write = grad_wr && grad_addr == addr_w'(img_w * img_h - 1);

    // ------------------------------------------------------------------
    // memory write port
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        grad_addr <= grad.addr;
        // memory takes the word as one raw value
        grad_do   <= grad.word.raw;
        if (reset) begin
            grad_wr <= 1'b0;
        end else begin
            grad_wr <= grad.valid;
        end
    end

    // sticky until the next reset
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (last_write) begin
            done <= 1'b1;
        end
    end

endmodule

// ==== hdl/gradient_calc.sv ====
`timescale 1ns/1ps

module gradient_calc
    import ig_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  window_t    win,
    output grad_beat_t grad
);

    logic signed [diff_w-1:0] cur_s;
    logic signed [diff_w-1:0] right_s;
    logic signed [diff_w-1:0] below_s;
    logic signed [diff_w-1:0] gx;
    logic signed [diff_w-1:0] gy;
    grad_word_u               word_n;

    // zero-extend pixels into the signed range
    assign cur_s   = signed'({{(diff_w - pix_w){1'b0}}, win.cur});
    assign right_s = signed'({{(diff_w - pix_w){1'b0}}, win.right});
    assign below_s = signed'({{(diff_w - pix_w){1'b0}}, win.below});

    assign gx = right_s - cur_s;
    assign gy = below_s - cur_s;

    // ------------------------------------------------------------------
    // edge masking and packing
    // ------------------------------------------------------------------
    always_comb begin
        word_n.f.gx = win.last_col ? '0 : gx;
        word_n.f.gy = win.last_row ? '0 : gy;
    end

    always_ff @(posedge clk) begin
        grad.addr <= win.addr;
        grad.word <= word_n;
        if (reset) begin
            grad.valid <= 1'b0;
        end else begin
            grad.valid <= win.valid;
        end
    end

endmodule

// ==== hdl/ig_pkg.sv ====
package ig_pkg;

    // ------------------------------------------------------------------
    // image geometry
    // ------------------------------------------------------------------
    localparam int img_w      = 256;
    localparam int img_h      = 256;
    localparam int addr_w     = 16;
    localparam int pix_w      = 8;
    localparam int coord_w    = $clog2(img_w);
    localparam int diff_w     = 10;
    localparam int grad_w     = 2 * diff_w;
    // one full line plus the pixel below
    localparam int line_delay = img_w + 1;

    // ------------------------------------------------------------------
    // stage beats
    // ------------------------------------------------------------------
    // fetch to window
    typedef struct packed {
        logic               valid;
        logic               flush;
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
        logic [pix_w-1:0]   pixel;
    } pix_beat_t;

    // window to calc
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
        logic [pix_w-1:0]  cur;
        logic [pix_w-1:0]  right;
        logic [pix_w-1:0]  below;
        logic              last_col;
        logic              last_row;
    } window_t;

    // gx in the upper half
    typedef struct packed {
        logic signed [diff_w-1:0] gx;
        logic signed [diff_w-1:0] gy;
    } grad_fields_t;

    typedef union packed {
        grad_fields_t      f;
        logic [grad_w-1:0] raw;
    } grad_word_u;

    // calc to writer
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
        grad_word_u        word;
    } grad_beat_t;

endpackage

// ==== hdl/ig_top.sv ====
`timescale 1ns/1ps

module ig_top
    import ig_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    output logic              img_rd,
    output logic [addr_w-1:0] img_addr,
    input  logic [pix_w-1:0]  img_di,
    output logic              grad_wr,
    output logic [addr_w-1:0] grad_addr,
    output logic [grad_w-1:0] grad_do,
    output logic              done
);

    pix_beat_t  pix_beat;
    window_t    win;
    grad_beat_t grad;

    // ------------------------------------------------------------------
    // fetch, window, calc, write
    // ------------------------------------------------------------------
    pixel_fetch fetch_i (
        .clk      (clk),
        .reset    (reset),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .img_di   (img_di),
        .beat     (pix_beat)
    );

    line_window window_i (
        .clk   (clk),
        .reset (reset),
        .beat  (pix_beat),
        .win   (win)
    );

    gradient_calc calc_i (
        .clk   (clk),
        .reset (reset),
        .win   (win),
        .grad  (grad)
    );

    grad_writer writer_i (
        .clk       (clk),
        .reset     (reset),
        .grad      (grad),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

endmodule

// ==== hdl/line_window.sv ====
`timescale 1ns/1ps

module line_window
    import ig_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  pix_beat_t beat,
    output window_t   win
);

    // together with the incoming pixel this spans line_delay beats
    logic [pix_w-1:0]  line_q [line_delay-1];
    logic [pix_w-1:0]  pix_in;
    logic              start;
    logic              running;
    logic              emit;
    logic              emit_done;
    logic [addr_w-1:0] emit_addr;

    // flush beats carry no pixel
    assign pix_in = beat.flush ? '0 : beat.pixel;

    // ------------------------------------------------------------------
    // line shift register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (beat.valid) begin
            line_q[0] <= pix_in;
            for (int i = 1; i < line_delay - 1; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    // first pixel of row 1 is the beat that fills the window
    assign start = beat.valid && !beat.flush && beat.x == '0
                   && beat.y == coord_w'(1);
    assign emit  = beat.valid && (running || start) && !emit_done;

    // ------------------------------------------------------------------
    // emit counter and output register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        win.addr     <= emit_addr;
        win.cur      <= line_q[line_delay-2];
        win.right    <= line_q[line_delay-3];
        win.below    <= pix_in;
        win.last_col <= emit_addr[coord_w-1:0] == coord_w'(img_w - 1);
        win.last_row <= emit_addr[addr_w-1:coord_w] == coord_w'(img_h - 1);
        if (reset) begin
            running   <= 1'b0;
            emit_done <= 1'b0;
            emit_addr <= '0;
            win.valid <= 1'b0;
        end else begin
            win.valid <= emit;
            if (start) begin
                running <= 1'b1;
            end
            if (emit) begin
                emit_addr <= emit_addr + 1'b1;
                // the trailing flush beat finds nothing left to emit
                if (emit_addr == addr_w'(img_w * img_h - 1)) begin
                    emit_done <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/pixel_fetch.sv ====
`timescale 1ns/1ps

module pixel_fetch
    import ig_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    output logic              img_rd,
    output logic [addr_w-1:0] img_addr,
    input  logic [pix_w-1:0]  img_di,
    output pix_beat_t         beat
);

    logic                          started;
    logic                          flushing;
    logic [$clog2(line_delay)-1:0] flush_cnt;
    logic                          rd_q;
    logic                          flush_q;
    logic [addr_w-1:0]             addr_q;

    // ------------------------------------------------------------------
    // read sequencer: one raster pass, then the flush run
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            started   <= 1'b0;
            img_rd    <= 1'b0;
            img_addr  <= '0;
            flushing  <= 1'b0;
            flush_cnt <= '0;
        end else if (!started) begin
            started <= 1'b1;
            img_rd  <= 1'b1;
        end else if (img_rd) begin
            if (img_addr == addr_w'(img_w * img_h - 1)) begin
                img_rd   <= 1'b0;
                flushing <= 1'b1;
            end else begin
                img_addr <= img_addr + 1'b1;
            end
        end else if (flushing) begin
            // line_delay beats in total
            if (int'(flush_cnt) == line_delay - 1) begin
                flushing <= 1'b0;
            end
            flush_cnt <= flush_cnt + 1'b1;
        end
    end

    // address held one cycle to meet the returning pixel
    always_ff @(posedge clk) begin
        addr_q <= img_addr;
        if (reset) begin
            rd_q    <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            rd_q    <= img_rd;
            flush_q <= flushing;
        end
    end

    assign beat.valid = rd_q | flush_q;
    assign beat.flush = flush_q;
    assign beat.x     = addr_q[coord_w-1:0];
    assign beat.y     = addr_q[addr_w-1:coord_w];
    assign beat.pixel = img_di;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the image gradient testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module ig_tb -f build.f -o ig_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/ig_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" <<< "$output"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi

// ==== verif/ig_tb.sv ====
`timescale 1ns/1ps

module ig_tb
    import ig_pkg::*;
();

    localparam int clk_period   = 100;
    localparam int drive_delay  = 1;
    localparam int reset_cycles = 16;
    localparam int num_pixels   = img_w * img_h;
    localparam int num_tests    = 6;
    localparam int settle_cycles = 20;
    localparam int max_print    = 20;
    // each pass is one read sweep, the flush run and the reset
    localparam int max_cycles   = num_tests * (num_pixels + 600 + reset_cycles) + 1000;

    localparam logic [3:0] pat_const = 4'd0;
    localparam logic [3:0] pat_hramp = 4'd1;
    localparam logic [3:0] pat_vramp = 4'd2;
    localparam logic [3:0] pat_check = 4'd3;
    localparam logic [3:0] pat_rand  = 4'd4;

    // pattern, constant or step, expected word at pixel (0,0)
    typedef struct packed {
        logic [3:0]        code;
        logic [pix_w-1:0]  value;
        logic              corner_chk;
        logic [grad_w-1:0] corner;
    } test_row_t;

    logic              clk;
    logic              reset;
    logic              img_rd;
    logic [addr_w-1:0] img_addr;
    logic [pix_w-1:0]  img_di;
    logic              grad_wr;
    logic [addr_w-1:0] grad_addr;
    logic [grad_w-1:0] grad_do;
    logic              done;

    logic [pix_w-1:0]  img_mem [num_pixels];
    logic [grad_w-1:0] grad_mem [num_pixels];
    logic [grad_w-1:0] ref_mem [num_pixels];
    test_row_t         rows [num_tests];
    logic [15:0]       lfsr_state;
    logic              rd_seen;
    logic [addr_w-1:0] rd_addr_seen;
    grad_word_u        live_word;
    int rd_count;
    int wr_count;
    int cycle_cnt;
    int read_errs;
    int value_errs;
    int edge_errs;
    int write_errs;
    int ctrl_errs;

    ig_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // memory models and bus monitor
    // ------------------------------------------------------------------
    // pixel returned one cycle after the read
    always @(posedge clk) begin
        #(drive_delay);
        img_di = rd_seen ? img_mem[rd_addr_seen] : '0;
    end

    always @(negedge clk) begin
        rd_seen      = img_rd && !reset;
        rd_addr_seen = img_addr;
        if (!reset && img_rd) begin
            assert (rd_count < num_pixels) else begin
                $display("read issued after the last pixel at address %h", img_addr);
                read_errs++;
            end
            if (rd_count < num_pixels) begin
                assert (img_addr == addr_w'(rd_count)) else begin
                    $display("ERR img_addr got %h expected %h", img_addr, addr_w'(rd_count));
                    read_errs++;
                end
            end
            rd_count++;
        end
        if (!reset && grad_wr) begin
            live_word = grad_do;
            assert (!done) else begin
                $display("write to the gradient memory after done was raised");
                write_errs++;
            end
            assert (wr_count < num_pixels) else begin
                $display("more writes than pixels, extra one at address %h", grad_addr);
                write_errs++;
            end
            if (wr_count < num_pixels) begin
                assert (grad_addr == addr_w'(wr_count)) else begin
                    $display("ERR grad_addr got %h expected %h",
                             grad_addr, addr_w'(wr_count));
                    write_errs++;
                end
            end
            // last column and last row carry zero differences
            if (grad_addr[coord_w-1:0] == coord_w'(img_w - 1)) begin
                assert (live_word.f.gx == '0) else begin
                    $display("ERR grad_do gx got %h expected %h", live_word.f.gx, 10'h0);
                    edge_errs++;
                end
            end
            if (grad_addr[addr_w-1:coord_w] == coord_w'(img_h - 1)) begin
                assert (live_word.f.gy == '0) else begin
                    $display("ERR grad_do gy got %h expected %h", live_word.f.gy, 10'h0);
                    edge_errs++;
                end
            end
            grad_mem[grad_addr] = grad_do;
            wr_count++;
        end
    end

    // ------------------------------------------------------------------
    // stimulus and reference
    // ------------------------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [grad_w-1:0] expected_word(input int x, input int y);
        int cur;
        int gx;
        int gy;
        cur = int'(img_mem[y * img_w + x]);
        gx  = (x == img_w - 1) ? 0 : int'(img_mem[y * img_w + x + 1]) - cur;
        gy  = (y == img_h - 1) ? 0 : int'(img_mem[(y + 1) * img_w + x]) - cur;
        return {diff_w'(gx), diff_w'(gy)};
    endfunction

    task automatic fill_image(input test_row_t row);
        logic [pix_w-1:0] px;
        for (int y = 0; y < img_h; y++) begin
            for (int x = 0; x < img_w; x++) begin
                case (row.code)
                    pat_hramp: px = pix_w'(x * int'(row.value));
                    pat_vramp: px = pix_w'(y * int'(row.value));
                    pat_check: px = ((x ^ y) & 1) != 0 ? 8'hff : 8'h00;
                    pat_rand: begin
                        px = '0;
                        for (int b = 0; b < pix_w; b++) begin
                            lfsr_state = lfsr_next(lfsr_state);
                            px = {px[pix_w-2:0], lfsr_state[0]};
                        end
                    end
                    default: px = row.value;
                endcase
                img_mem[y * img_w + x] = px;
            end
        end
    endtask

    task automatic build_reference();
        for (int y = 0; y < img_h; y++) begin
            for (int x = 0; x < img_w; x++) begin
                ref_mem[y * img_w + x] = expected_word(x, y);
                // marker so that a missed write shows up
                grad_mem[y * img_w + x] = {4'hd, addr_w'(y * img_w + x)} ^ 20'h5a5a5;
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #(drive_delay);
        reset    = 1'b1;
        rd_count = 0;
        wr_count = 0;
        repeat (reset_cycles - 1) @(posedge clk);
        @(negedge clk);
        assert (!done && !img_rd && !grad_wr) else begin
            $display("done, img_rd or grad_wr not low during reset");
            ctrl_errs++;
        end
        @(posedge clk);
        #(drive_delay);
        reset = 1'b0;
    endtask

    task automatic check_results(input int t);
        assert (rd_count == num_pixels) else begin
            $display("test %0d saw %0d reads instead of %0d", t, rd_count, num_pixels);
            read_errs++;
        end
        assert (wr_count == num_pixels) else begin
            $display("test %0d saw %0d writes instead of %0d", t, wr_count, num_pixels);
            write_errs++;
        end
        if (rows[t].corner_chk) begin
            assert (grad_mem[0] == rows[t].corner) else begin
                $display("ERR grad_do at 0 got %h expected %h", grad_mem[0], rows[t].corner);
                value_errs++;
            end
        end
        for (int a = 0; a < num_pixels; a++) begin
            assert (grad_mem[a] == ref_mem[a]) else begin
                if (value_errs < max_print) begin
                    $display("ERR grad_do at %h got %h expected %h",
                             addr_w'(a), grad_mem[a], ref_mem[a]);
                end
                value_errs++;
            end
        end
    endtask

    initial begin
        reset      = 1'b1;
        img_di     = '0;
        rd_seen    = 1'b0;
        lfsr_state = 16'd61;
        cycle_cnt  = 0;
        rd_count   = 0;
        wr_count   = 0;
        read_errs  = 0;
        value_errs = 0;
        edge_errs  = 0;
        write_errs = 0;
        ctrl_errs  = 0;
        rows[0] = '{pat_const, 8'd0,   1'b1, 20'h00000};
        rows[1] = '{pat_const, 8'd255, 1'b1, 20'h00000};
        rows[2] = '{pat_hramp, 8'd1,   1'b1, 20'h00400};
        rows[3] = '{pat_vramp, 8'd3,   1'b1, 20'h00003};
        // 0 next to 255 both ways
        rows[4] = '{pat_check, 8'd0,   1'b1, 20'h3fcff};
        rows[5] = '{pat_rand,  8'd0,   1'b0, 20'h00000};

        for (int t = 0; t < num_tests; t++) begin
            fill_image(rows[t]);
            build_reference();
            apply_reset();
            while (!done) @(negedge clk);
            repeat (settle_cycles) @(negedge clk);
            check_results(t);
        end

        $display("errors: read %0d, value %0d, edge %0d, write %0d, control %0d",
                 read_errs, value_errs, edge_errs, write_errs, ctrl_errs);
        if (read_errs + value_errs + edge_errs + write_errs + ctrl_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
